/* src/mips_pkg.sv */
// ==================================================
// shared types and constants for the pipelined core
// imported by wildcard in each stage module header
// ==================================================
package mips_pkg;

	// widths that carry a meaning
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  dmem_addr_t;
	typedef logic [1:0]  alu_op_t;

	// opcodes
	localparam logic [5:0] OP_RTYPE = 6'd0;
	localparam logic [5:0] OP_BEQ   = 6'd4;
	localparam logic [5:0] OP_ADDI  = 6'd8;
	localparam logic [5:0] OP_LW    = 6'd35;
	localparam logic [5:0] OP_SW    = 6'd43;

	// R-type funct codes, also used as the ALU function select
	localparam logic [5:0] FN_ADD = 6'd32;
	localparam logic [5:0] FN_SUB = 6'd34;
	localparam logic [5:0] FN_AND = 6'd36;
	localparam logic [5:0] FN_OR  = 6'd37;
	localparam logic [5:0] FN_SLT = 6'd42;

	// ALU classes from main control
	localparam alu_op_t ALUOP_ADD   = 2'b00;
	localparam alu_op_t ALUOP_SUB   = 2'b01;
	localparam alu_op_t ALUOP_FUNCT = 2'b10;

	localparam int DMEM_WORDS = 64;

	// ==================================================
	// pipeline bundles
	// ==================================================
	typedef struct packed {
		logic    regdst;
		logic    alusrc;
		logic    branch;
		logic    memread;
		logic    memwrite;
		logic    memtoreg;
		logic    regwrite;
		alu_op_t aluop;
	} ctrl_t;

	typedef struct packed {
		word_t pc_next;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t      ctrl;
		word_t      pc_next;
		word_t      rs_val;
		word_t      rt_val;
		word_t      imm;
		reg_addr_t  rt_addr;
		reg_addr_t  rd_addr;
		logic [5:0] funct;
	} id_ex_t;

	typedef struct packed {
		ctrl_t     ctrl;
		word_t     branch_target;
		logic      zero;
		word_t     alu_result;
		word_t     store_data;
		reg_addr_t wr_reg;
	} ex_mem_t;

	typedef struct packed {
		logic      regwrite;
		logic      memtoreg;
		word_t     read_data;
		word_t     alu_result;
		reg_addr_t wr_reg;
	} mem_wb_t;

	// redirect from the memory stage back to fetch
	typedef struct packed {
		logic  taken;
		word_t target;
	} branch_t;

endpackage

/* src/fetch_stage.sv */
// ==================================================
// instruction fetch: program counter and IF/ID register
// ==================================================
`timescale 1ns/1ps

module fetch_stage import mips_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_arst_n,
	input  branch_t i_branch,
	output word_t   o_pc,
	input  word_t   i_instr,
	output if_id_t  o_if_id
);

	word_t pc;
	word_t pc_plus4;

	assign pc_plus4 = pc + 32'd4;
	assign o_pc     = pc;

	// a taken branch overrides the sequential address
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			pc <= '0;
		else if (i_branch.taken)
			pc <= i_branch.target;
		else
			pc <= pc_plus4;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_if_id <= '0;
		else
		begin
			o_if_id.pc_next <= pc_plus4;
			o_if_id.instr   <= i_instr;
		end
	end

endmodule

/* src/main_control.sv */
// ==================================================
// opcode decoder that builds the control bundle
// ==================================================
`timescale 1ns/1ps

module main_control import mips_pkg::*;
(
	input  logic [5:0] i_opcode,
	output ctrl_t      o_ctrl
);

	always_comb
	begin
		// unknown opcodes fall through as a nop
		o_ctrl = '0;
		case (i_opcode)
			OP_RTYPE:
			begin
				o_ctrl.regdst   = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_FUNCT;
			end
			OP_ADDI:
			begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end
			OP_LW:
			begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.memread  = 1'b1;
				o_ctrl.memtoreg = 1'b1;
				o_ctrl.regwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end
			OP_SW:
			begin
				o_ctrl.alusrc   = 1'b1;
				o_ctrl.memwrite = 1'b1;
				o_ctrl.aluop    = ALUOP_ADD;
			end
			OP_BEQ:
			begin
				o_ctrl.branch = 1'b1;
				o_ctrl.aluop  = ALUOP_SUB;
			end
			default:
				o_ctrl = '0;
		endcase
	end

endmodule

/* src/register_bank.sv */
// ==================================================
// 32 x 32 register file, two read ports, one write
// port; writes in the same cycle bypass to the reads
// ==================================================
`timescale 1ns/1ps

module register_bank import mips_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  reg_addr_t i_rs_addr,
	input  reg_addr_t i_rt_addr,
	input  logic      i_wr_en,
	input  reg_addr_t i_wr_addr,
	input  word_t     i_wr_data,
	output word_t     o_rs_data,
	output word_t     o_rt_data
);

	word_t regs [32];

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (i_wr_en && (i_wr_addr != '0))
			regs[i_wr_addr] <= i_wr_data;
	end

	// r0 reads zero, otherwise new data wins over the stored word
	always_comb
	begin
		if (i_rs_addr == '0)
			o_rs_data = '0;
		else if (i_wr_en && (i_wr_addr == i_rs_addr))
			o_rs_data = i_wr_data;
		else
			o_rs_data = regs[i_rs_addr];

		if (i_rt_addr == '0)
			o_rt_data = '0;
		else if (i_wr_en && (i_wr_addr == i_rt_addr))
			o_rt_data = i_wr_data;
		else
			o_rt_data = regs[i_rt_addr];
	end

endmodule

/* src/decode_stage.sv */
// ==================================================
// instruction decode: field split, register read,
// immediate extension and the ID/EX register
// ==================================================
`timescale 1ns/1ps

module decode_stage import mips_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_arst_n,
	input  if_id_t    i_if_id,
	input  logic      i_wb_en,
	input  reg_addr_t i_wb_addr,
	input  word_t     i_wb_data,
	output id_ex_t    o_id_ex
);

	// ==================================================
	// instruction fields
	// ==================================================
	logic [5:0]  opcode;
	reg_addr_t   rs_addr;
	reg_addr_t   rt_addr;
	reg_addr_t   rd_addr;
	logic [15:0] imm16;
	logic [5:0]  funct;

	assign opcode  = i_if_id.instr[31:26];
	assign rs_addr = i_if_id.instr[25:21];
	assign rt_addr = i_if_id.instr[20:16];
	assign rd_addr = i_if_id.instr[15:11];
	assign imm16   = i_if_id.instr[15:0];
	assign funct   = i_if_id.instr[5:0];

	ctrl_t ctrl;
	word_t rs_val;
	word_t rt_val;
	word_t imm_ext;

	// sign extension
	assign imm_ext = {{16{imm16[15]}}, imm16};

	main_control u_main_control (
		.i_opcode (opcode),
		.o_ctrl   (ctrl)
	);

	register_bank u_register_bank (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_rs_addr (rs_addr),
		.i_rt_addr (rt_addr),
		.i_wr_en   (i_wb_en),
		.i_wr_addr (i_wb_addr),
		.i_wr_data (i_wb_data),
		.o_rs_data (rs_val),
		.o_rt_data (rt_val)
	);

	// ==================================================
	// ID/EX register
	// ==================================================
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_id_ex <= '0;
		else
		begin
			o_id_ex.ctrl    <= ctrl;
			o_id_ex.pc_next <= i_if_id.pc_next;
			o_id_ex.rs_val  <= rs_val;
			o_id_ex.rt_val  <= rt_val;
			o_id_ex.imm     <= imm_ext;
			o_id_ex.rt_addr <= rt_addr;
			o_id_ex.rd_addr <= rd_addr;
			o_id_ex.funct   <= funct;
		end
	end

endmodule

/* src/execute_stage.sv */
// ==================================================
// execute: ALU control, ALU, branch target and the
// EX/MEM register
// ==================================================
`timescale 1ns/1ps

module execute_stage import mips_pkg::*;
(
	input  logic    i_clk,
	input  logic    i_arst_n,
	input  id_ex_t  i_id_ex,
	output ex_mem_t o_ex_mem
);

	logic [5:0] alu_fn;
	word_t      op_a;
	word_t      op_b;
	word_t      alu_result;
	word_t      branch_target;
	reg_addr_t  wr_reg;

	// ALU function expressed as a funct code
	always_comb
	begin
		case (i_id_ex.ctrl.aluop)
			ALUOP_ADD:   alu_fn = FN_ADD;
			ALUOP_SUB:   alu_fn = FN_SUB;
			ALUOP_FUNCT: alu_fn = i_id_ex.funct;
			default:     alu_fn = FN_ADD;
		endcase
	end

	assign op_a = i_id_ex.rs_val;
	assign op_b = i_id_ex.ctrl.alusrc ? i_id_ex.imm : i_id_ex.rt_val;

	always_comb
	begin
		case (alu_fn)
			FN_ADD:  alu_result = op_a + op_b;
			FN_SUB:  alu_result = op_a - op_b;
			FN_AND:  alu_result = op_a & op_b;
			FN_OR:   alu_result = op_a | op_b;
			// signed compare
			FN_SLT:  alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_result = '0;
		endcase
	end

	// word offset relative to pc+4
	assign branch_target = i_id_ex.pc_next + {i_id_ex.imm[29:0], 2'b00};
	assign wr_reg        = i_id_ex.ctrl.regdst ? i_id_ex.rd_addr : i_id_ex.rt_addr;

	// ==================================================
	// EX/MEM register
	// ==================================================
	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_ex_mem <= '0;
		else
		begin
			o_ex_mem.ctrl          <= i_id_ex.ctrl;
			o_ex_mem.branch_target <= branch_target;
			o_ex_mem.zero          <= (alu_result == '0);
			o_ex_mem.alu_result    <= alu_result;
			o_ex_mem.store_data    <= i_id_ex.rt_val;
			o_ex_mem.wr_reg        <= wr_reg;
		end
	end

endmodule

/* src/memory_stage.sv */
// ==================================================
// memory access: 64-word data memory, branch decision
// and the MEM/WB register
// ==================================================
`timescale 1ns/1ps

module memory_stage import mips_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_arst_n,
	input  ex_mem_t    i_ex_mem,
	output branch_t    o_branch,
	output logic       o_st_valid,
	output dmem_addr_t o_st_addr,
	output word_t      o_st_data,
	output mem_wb_t    o_mem_wb
);

	word_t      dmem [DMEM_WORDS];
	dmem_addr_t idx;
	word_t      read_data;

	// word index from the byte address
	assign idx       = i_ex_mem.alu_result[7:2];
	assign read_data = i_ex_mem.ctrl.memread ? dmem[idx] : '0;

	assign o_st_valid = i_ex_mem.ctrl.memwrite;
	assign o_st_addr  = idx;
	assign o_st_data  = i_ex_mem.store_data;

	assign o_branch.taken  = i_ex_mem.ctrl.branch & i_ex_mem.zero;
	assign o_branch.target = i_ex_mem.branch_target;

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			for (int i = 0; i < DMEM_WORDS; i++)
				dmem[i] <= '0;
		end
		else if (i_ex_mem.ctrl.memwrite)
			dmem[idx] <= i_ex_mem.store_data;
	end

	always_ff @(posedge i_clk or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_mem_wb <= '0;
		else
		begin
			o_mem_wb.regwrite   <= i_ex_mem.ctrl.regwrite;
			o_mem_wb.memtoreg   <= i_ex_mem.ctrl.memtoreg;
			o_mem_wb.read_data  <= read_data;
			o_mem_wb.alu_result <= i_ex_mem.alu_result;
			o_mem_wb.wr_reg     <= i_ex_mem.wr_reg;
		end
	end

endmodule

/* src/mips_core.sv */
// ==================================================
// five-stage MIPS subset core; instruction memory is
// external and read in the same cycle as the address
// ==================================================
`timescale 1ns/1ps

module mips_core import mips_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_arst_n,
	output word_t      o_imem_addr,
	input  word_t      i_imem_data,
	output logic       o_wb_valid,
	output reg_addr_t  o_wb_addr,
	output word_t      o_wb_data,
	output logic       o_st_valid,
	output dmem_addr_t o_st_addr,
	output word_t      o_st_data
);

	// ==================================================
	// pipeline registers and back paths
	// ==================================================
	if_id_t  if_id;
	id_ex_t  id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;
	branch_t branch;

	fetch_stage u_fetch (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_branch (branch),
		.o_pc     (o_imem_addr),
		.i_instr  (i_imem_data),
		.o_if_id  (if_id)
	);

	decode_stage u_decode (
		.i_clk     (i_clk),
		.i_arst_n  (i_arst_n),
		.i_if_id   (if_id),
		.i_wb_en   (o_wb_valid),
		.i_wb_addr (o_wb_addr),
		.i_wb_data (o_wb_data),
		.o_id_ex   (id_ex)
	);

	execute_stage u_execute (
		.i_clk    (i_clk),
		.i_arst_n (i_arst_n),
		.i_id_ex  (id_ex),
		.o_ex_mem (ex_mem)
	);

	memory_stage u_memory (
		.i_clk      (i_clk),
		.i_arst_n   (i_arst_n),
		.i_ex_mem   (ex_mem),
		.o_branch   (branch),
		.o_st_valid (o_st_valid),
		.o_st_addr  (o_st_addr),
		.o_st_data  (o_st_data),
		.o_mem_wb   (mem_wb)
	);

	// writeback select; writes to r0 are dropped here
	assign o_wb_data  = mem_wb.memtoreg ? mem_wb.read_data : mem_wb.alu_result;
	assign o_wb_addr  = mem_wb.wr_reg;
	assign o_wb_valid = mem_wb.regwrite && (mem_wb.wr_reg != '0);

endmodule

/* sim/mips_core_props.sv */
// ==================================================
// concurrent checks on the core ports, bound to mips_core
// ==================================================
`timescale 1ns/1ps

module mips_core_props import mips_pkg::*;
(
	input logic      i_clk,
	input logic      i_arst_n,
	input word_t     i_imem_addr,
	input logic      i_wb_valid,
	input reg_addr_t i_wb_addr,
	input logic      i_st_valid,
	input ex_mem_t   i_ex_mem
);

	a_no_wb_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !i_wb_valid)
		else $error("writeback strobe high during reset");

	a_wb_not_r0: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		i_wb_valid |-> (i_wb_addr != '0))
		else $error("writeback strobe with destination r0");

	// fetch addresses stay word aligned
	a_pc_aligned: assert property (@(posedge i_clk) i_imem_addr[1:0] == 2'b00)
		else $error("instruction address not word aligned");

	a_st_ld_excl: assert property (@(posedge i_clk) disable iff (!i_arst_n)
		!(i_st_valid && i_ex_mem.ctrl.memread))
		else $error("store and load together in the memory stage");

endmodule

bind mips_core mips_core_props u_props (
	.i_clk       (i_clk),
	.i_arst_n    (i_arst_n),
	.i_imem_addr (o_imem_addr),
	.i_wb_valid  (o_wb_valid),
	.i_wb_addr   (o_wb_addr),
	.i_st_valid  (o_st_valid),
	.i_ex_mem    (ex_mem)
);

/* sim/tb_mips_core.sv */
// ==================================================
// random program testbench for the pipelined core,
// checked against an architectural reference model
// ==================================================
`timescale 1ns/1ps

module tb_mips_core import mips_pkg::*;
();

	localparam int ROM_WORDS  = 256;
	localparam int NUM_GROUPS = 40;

	typedef struct packed {
		reg_addr_t addr;
		word_t     data;
	} wb_ev_t;

	typedef struct packed {
		dmem_addr_t addr;
		word_t      data;
	} st_ev_t;

	logic       i_clk;
	logic       i_arst_n;
	word_t      o_imem_addr;
	word_t      i_imem_data;
	logic       o_wb_valid;
	reg_addr_t  o_wb_addr;
	word_t      o_wb_data;
	logic       o_st_valid;
	dmem_addr_t o_st_addr;
	word_t      o_st_data;

	word_t  rom [ROM_WORDS];
	word_t  end_pc;
	int     prog_len = 0;
	integer seed;
	int     errors = 0;
	int     wb_checked = 0;
	int     st_checked = 0;
	wb_ev_t wb_exp;
	st_ev_t st_exp;

	// expected event streams from the reference model
	word_t  exp_fetch [$];
	wb_ev_t exp_wb [$];
	st_ev_t exp_st [$];

	mips_core uut (
		.i_clk       (i_clk),
		.i_arst_n    (i_arst_n),
		.o_imem_addr (o_imem_addr),
		.i_imem_data (i_imem_data),
		.o_wb_valid  (o_wb_valid),
		.o_wb_addr   (o_wb_addr),
		.o_wb_data   (o_wb_data),
		.o_st_valid  (o_st_valid),
		.o_st_addr   (o_st_addr),
		.o_st_data   (o_st_data)
	);

	// combinational instruction ROM
	assign i_imem_data = rom[o_imem_addr[9:2]];

	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// ==================================================
	// program generation
	// ==================================================
	function automatic int rand_below(input int n);
		int r;
		r = $random(seed) & 32'h7fffffff;
		return r % n;
	endfunction

	// registers r0..r7 only so operands repeat
	function automatic reg_addr_t rand_reg();
		reg_addr_t r;
		r = 5'(rand_below(8));
		return r;
	endfunction

	function automatic logic [5:0] pick_funct();
		case (rand_below(5))
			0:       return FN_ADD;
			1:       return FN_SUB;
			2:       return FN_AND;
			3:       return FN_OR;
			default: return FN_SLT;
		endcase
	endfunction

	function automatic word_t enc_r(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [5:0] fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t enc_i(input logic [5:0] op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic void generate_program();
		int        pos;
		int        groups;
		int        plain_left;
		int        kind;
		int        skip;
		reg_addr_t rs;
		reg_addr_t rt;
		word_t     rnd;
		for (int i = 0; i < ROM_WORDS; i++)
			rom[i] = '0;
		pos = 0;
		for (int r = 1; r < 8; r++)
		begin
			rnd = $random(seed);
			rom[pos] = enc_i(OP_ADDI, 5'd0, 5'(r), rnd[15:0]);
			pos++;
		end
		pos += 2;
		groups = 0;
		plain_left = 0;
		// skipped groups after a beq must be three words each
		while (groups < NUM_GROUPS || plain_left > 0)
		begin
			kind = (plain_left > 0) ? rand_below(4) : rand_below(5);
			rs = rand_reg();
			rt = rand_reg();
			rnd = $random(seed);
			case (kind)
				0: rom[pos] = enc_r(rs, rt, rand_reg(), pick_funct());
				1: rom[pos] = enc_i(OP_ADDI, rs, rt, rnd[15:0]);
				2: rom[pos] = enc_i(OP_LW, 5'd0, rt, {11'd0, rnd[2:0], 2'b00});
				3: rom[pos] = enc_i(OP_SW, 5'd0, rt, {11'd0, rnd[2:0], 2'b00});
				default:
				begin
					if (rnd[3])
						rt = rs;
					skip = rand_below(3);
					rom[pos] = enc_i(OP_BEQ, rs, rt, 16'(3 + 3 * skip));
					plain_left = skip;
				end
			endcase
			pos += (kind == 4) ? 4 : 3;
			if (kind != 4 && plain_left > 0)
				plain_left--;
			groups++;
		end
		// closing self loop
		rom[pos] = enc_i(OP_BEQ, 5'd0, 5'd0, 16'hffff);
		end_pc = pos * 4;
		prog_len = pos + 1;
	endfunction

	// ==================================================
	// reference model
	// ==================================================
	function automatic void run_reference();
		word_t     regs [32];
		word_t     dmem [64];
		word_t     pc;
		word_t     instr;
		word_t     a;
		word_t     b;
		word_t     imm;
		word_t     res;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		wb_ev_t    wb_ev;
		st_ev_t    st_ev;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		for (int i = 0; i < 64; i++)
			dmem[i] = '0;
		pc = '0;
		while (pc != end_pc)
		begin
			instr = rom[pc[9:2]];
			exp_fetch.push_back(pc);
			rs = instr[25:21];
			rt = instr[20:16];
			rd = instr[15:11];
			a = regs[rs];
			b = regs[rt];
			imm = {{16{instr[15]}}, instr[15:0]};
			pc = pc + 32'd4;
			wb_ev.addr = '0;
			case (instr[31:26])
				OP_RTYPE:
				begin
					case (instr[5:0])
						FN_ADD:  res = a + b;
						FN_SUB:  res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: res = '0;
					endcase
					wb_ev.addr = rd;
				end
				OP_ADDI:
				begin
					res = a + imm;
					wb_ev.addr = rt;
				end
				OP_LW:
				begin
					res = a + imm;
					res = dmem[res[7:2]];
					wb_ev.addr = rt;
				end
				OP_SW:
				begin
					res = a + imm;
					st_ev.addr = res[7:2];
					st_ev.data = b;
					dmem[st_ev.addr] = b;
					exp_st.push_back(st_ev);
				end
				OP_BEQ:
				begin
					// three slots always fetched before the redirect
					exp_fetch.push_back(pc);
					exp_fetch.push_back(pc + 32'd4);
					exp_fetch.push_back(pc + 32'd8);
					if (a == b)
						pc = pc + (imm << 2);
					else
						pc = pc + 32'd12;
				end
				default:
					res = '0;
			endcase
			if (wb_ev.addr != '0)
			begin
				wb_ev.data = res;
				regs[wb_ev.addr] = res;
				exp_wb.push_back(wb_ev);
			end
		end
		exp_fetch.push_back(end_pc);
	endfunction

	// ==================================================
	// checking
	// ==================================================
	task automatic compare_value(input string name, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	always @(negedge i_clk)
	begin
		if (!i_arst_n && (o_wb_valid || o_st_valid))
		begin
			$display("strobe raised during reset at %0t", $time);
			errors++;
		end
		if (i_arst_n && exp_fetch.size() > 0)
			compare_value("o_imem_addr", o_imem_addr, exp_fetch.pop_front());
		if (o_wb_valid)
		begin
			if (exp_wb.size() == 0)
			begin
				$display("unexpected writeback to r%0d at %0t", o_wb_addr, $time);
				errors++;
			end
			else
			begin
				wb_exp = exp_wb.pop_front();
				compare_value("o_wb_addr", {27'd0, o_wb_addr}, {27'd0, wb_exp.addr});
				compare_value("o_wb_data", o_wb_data, wb_exp.data);
				wb_checked++;
			end
		end
		if (o_st_valid)
		begin
			if (exp_st.size() == 0)
			begin
				$display("unexpected store to word %0d at %0t", o_st_addr, $time);
				errors++;
			end
			else
			begin
				st_exp = exp_st.pop_front();
				compare_value("o_st_addr", {26'd0, o_st_addr}, {26'd0, st_exp.addr});
				compare_value("o_st_data", o_st_data, st_exp.data);
				st_checked++;
			end
		end
	end

	initial
	begin
		wait (prog_len > 0);
		repeat (prog_len * 8 + 200) @(posedge i_clk);
		$display("timeout: program did not finish within %0d cycles", prog_len * 8 + 200);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial
	begin
		i_arst_n <= 1'b0;
		seed = 32'h290d;
		generate_program();
		run_reference();
		repeat (10) @(posedge i_clk);
		i_arst_n <= 1'b1;
		while (exp_fetch.size() > 0)
			@(posedge i_clk);
		// last writeback lands four cycles after its fetch
		repeat (8) @(posedge i_clk);
		if (exp_wb.size() != 0 || exp_st.size() != 0)
		begin
			$display("events never seen: %0d writebacks, %0d stores",
				exp_wb.size(), exp_st.size());
			errors++;
		end
		$display("errors %0d, writebacks checked %0d, stores checked %0d",
			errors, wb_checked, st_checked);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* sources.f */
src/mips_pkg.sv
src/fetch_stage.sv
src/main_control.sv
src/register_bank.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
sim/mips_core_props.sv
sim/tb_mips_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the core and its testbench with Verilator, run, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mips_core -f sources.f

output=$(./obj_dir/Vtb_mips_core || true)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
	exit 0
fi
exit 1
